/* flist.f */
+incdir+src
src/lfo_pkg.sv
src/lfo_ctrl.sv
src/lfo_am_gen.sv
src/lfo_pm_gen.sv
src/lfo_noise.sv
src/lfo_top.sv
sim/lfo_tb.sv

/* Bender.yml */
package:
  name: lfo

sources:
  - include_dirs:
      - src
    files:
      - src/lfo_pkg.sv
      - src/lfo_ctrl.sv
      - src/lfo_am_gen.sv
      - src/lfo_pm_gen.sv
      - src/lfo_noise.sv
      - src/lfo_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/lfo_tb.sv

/* sim/lfo_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lfo_consts.svh"

module lfo_tb;
	import lfo_pkg::*;

	typedef struct packed {
		lfo_wave_e         wave;
		logic [7:0]        freq;
		logic [6:0]        amd;
		logic [6:0]        pmd;
		logic [7:0]        am_max; // Highest legal am.
		logic signed [7:0] pm_min; // Lowest legal pitch value.
		logic signed [7:0] pm_max; // Highest legal pitch value.
		logic [15:0]       len;    // Cycles observed after the restart.
	} row_t;

	localparam int NUM_ROWS = 6;

	logic                  clk;
	logic                  rst;
	logic                  zero;
	logic                  lfo_rst;
	logic [7:0]            freq;
	logic [`LFO_AM_W-1:0]  amd;
	logic [`LFO_PM_W-2:0]  pmd;
	logic [1:0]            wave;
	logic [`LFO_AM_W-1:0]  am;
	logic [`LFO_PM_W-1:0]  pm_u;

	row_t   rows [NUM_ROWS];
	integer seed = 32'h7339_88de;
	logic [31:0] rnd;
	int     errors = 0;
	int     cycle_cnt = 0;
	int     limit_cycles = 0;

	lfo_top lfo_top_inst (
		.clk     (clk),
		.rst     (rst),
		.zero    (zero),
		.lfo_rst (lfo_rst),
		.freq    (freq),
		.amd     (amd),
		.pmd     (pmd),
		.wave    (wave),
		.am      (am),
		.pm_u    (pm_u)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Random sample strobe on every clock.
	always @(posedge clk) begin
		rnd = $random(seed);
		zero <= rnd[0];
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > limit_cycles) begin
			$display("Timeout: the run went past %0d cycles without finishing", limit_cycles);
			$display("SOME TESTS FAILED");
			$fatal(1, "timeout");
		end
	end

	task automatic check_value(input string name, input int got, input int exp);
		if (got !== exp) begin
			errors++;
			$display("ERR t=%0t %s got %0d expected %0d", $time, name, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "check of %s failed", name);
		end
	endtask

	// Inverse of the sign over magnitude output stage.
	function automatic int decode_pitch(input logic [`LFO_PM_W-1:0] u);
		if (u[`LFO_PM_W-1]) begin
			return -1 - int'(u[`LFO_PM_W-2:0]);
		end else begin
			return int'(u[`LFO_PM_W-2:0]);
		end
	endfunction

	function automatic row_t make_row(input lfo_wave_e w, input logic [7:0] f,
		input logic [6:0] ad, input logic [6:0] pd, input int amx, input int pmn,
		input int pmx, input int n);
		row_t r;
		r.wave   = w;
		r.freq   = f;
		r.amd    = ad;
		r.pmd    = pd;
		r.am_max = 8'(amx);
		r.pm_min = 8'(pmn);
		r.pm_max = 8'(pmx);
		r.len    = 16'(n);
		return r;
	endfunction

	task automatic run_row(input row_t r);
		int amd_i;
		int pmd_i;
		int pm_lo;
		int pm_hi;
		int prev_am;
		int prev_pm;
		int cur_am;
		int cur_pm;
		bit top_seen;
		bit bot_seen;
		bit pos_seen;
		bit neg_seen;
		amd_i    = r.amd;
		pmd_i    = r.pmd;
		pm_lo    = $signed(r.pm_min);
		pm_hi    = $signed(r.pm_max);
		top_seen = 1'b0;
		bot_seen = 1'b0;
		pos_seen = 1'b0;
		neg_seen = 1'b0;
		@(posedge clk);
		wave    <= r.wave;
		freq    <= r.freq;
		amd     <= r.amd;
		pmd     <= r.pmd;
		lfo_rst <= 1'b1;
		@(posedge clk);
		lfo_rst <= 1'b0;
		@(negedge clk);
		check_value("am after restart", am, 0);
		check_value("pm_u after restart", pm_u, 0);
		prev_am = 0;
		prev_pm = 0;
		repeat (r.len) begin
			@(negedge clk);
			cur_am = am;
			cur_pm = decode_pitch(pm_u);
			if (cur_am > r.am_max) check_value("am", cur_am, r.am_max);
			if (cur_pm > pm_hi) check_value("pitch from pm_u", cur_pm, pm_hi);
			if (cur_pm < pm_lo) check_value("pitch from pm_u", cur_pm, pm_lo);
			case (r.wave)
				WAVE_SAW: begin
					if (cur_am != prev_am)
						check_value("am", cur_am, (prev_am == amd_i) ? 0 : prev_am + 1);
					if (cur_pm != prev_pm)
						check_value("pitch from pm_u", cur_pm,
							(prev_pm == pmd_i) ? -pmd_i : prev_pm + 1);
				end
				WAVE_TRI: begin
					if (cur_am - prev_am > 1 || prev_am - cur_am > 1)
						check_value("am", cur_am, prev_am); // Moved by more than one.
					if (cur_pm - prev_pm > 1 || prev_pm - cur_pm > 1)
						check_value("pitch from pm_u", cur_pm, prev_pm);
				end
				WAVE_SQUARE: begin
					if (cur_am != 0 && cur_am != amd_i)
						check_value("am", cur_am, amd_i);
					if (cur_pm != 0 && cur_pm != pmd_i && cur_pm != -pmd_i)
						check_value("pitch from pm_u", cur_pm, pmd_i);
				end
				default: ; // Noise only has the bounds above.
			endcase
			if (amd_i != 0 && cur_am == amd_i) top_seen = 1'b1;
			if (top_seen && cur_am == 0) bot_seen = 1'b1;
			if (pmd_i != 0 && cur_pm == pmd_i) pos_seen = 1'b1;
			if (pmd_i != 0 && cur_pm == -pmd_i) neg_seen = 1'b1;
			prev_am = cur_am;
			prev_pm = cur_pm;
		end
		if (r.wave == WAVE_TRI || r.wave == WAVE_SQUARE) begin
			check_value("am reached depth", top_seen, 1);
			check_value("pitch reached +depth", pos_seen, 1);
			check_value("pitch reached -depth", neg_seen, 1);
		end
		if (r.wave == WAVE_TRI) check_value("am came back to 0", bot_seen, 1);
	endtask

	initial begin
		rst     = 1'b1;
		zero    = 1'b0;
		lfo_rst = 1'b0;
		freq    = 8'h00;
		amd     = '0;
		pmd     = '0;
		wave    = 2'd0;

		// Wave, freq, amd, pmd, am max, pitch min, pitch max, cycles.
		rows[0] = make_row(WAVE_SAW,    8'hff, 7'd100, 7'd50, 100, -50, 50, 3000);
		rows[1] = make_row(WAVE_TRI,    8'hff, 7'd40,  7'd30, 40,  -30, 30, 5000);
		rows[2] = make_row(WAVE_SQUARE, 8'hff, 7'd77,  7'd45, 77,  -45, 45, 6000);
		rows[3] = make_row(WAVE_NOISE,  8'hff, 7'd5,   7'd3,  7,   -4,  3,  800);
		rows[4] = make_row(WAVE_NOISE,  8'hef, 7'd0,   7'd0,  0,   -1,  0,  400);
		rows[5] = make_row(WAVE_SAW,    8'hee, 7'd0,   7'd0,  0,   0,   0,  300);

		// Sum of the row lengths plus restart cycles, reset and margin.
		limit_cycles = 10 + 500;
		for (int i = 0; i < NUM_ROWS; i++) begin
			limit_cycles += rows[i].len + 3;
		end

		@(posedge clk);
		repeat (3) begin
			@(negedge clk);
			check_value("am in reset", am, 0);
			check_value("pm_u in reset", pm_u, 0);
			@(posedge clk);
		end
		rst <= 1'b0;

		for (int i = 0; i < NUM_ROWS; i++) begin
			run_row(rows[i]);
		end

		if (errors == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			$display("SOME TESTS FAILED");
			$fatal(1, "%0d checks failed", errors);
		end
	end

endmodule

`default_nettype wire

/* src/lfo_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lfo_consts.svh"

module lfo_top (
	input  wire                  clk,
	input  wire                  rst,
	input  wire                  zero,
	input  wire                  lfo_rst,
	input  wire  [7:0]           freq,
	input  wire  [`LFO_AM_W-1:0] amd,
	input  wire  [`LFO_PM_W-2:0] pmd,
	input  wire  [1:0]           wave,
	output logic [`LFO_AM_W-1:0] am,
	output logic [`LFO_PM_W-1:0] pm_u
);
	import lfo_pkg::*;

	logic                  tick;
	lfo_wave_e             wave_sel;
	logic [`LFO_LIM_W-1:0] cnt_lim;
	logic                  sq_flip;
	logic                  sq_high;
	logic [`LFO_AM_W-1:0]  noise_am;
	logic [`LFO_PM_W-1:0]  noise_pm;

	lfo_ctrl lfo_ctrl_inst (
		.clk      (clk),
		.rst      (rst),
		.lfo_rst  (lfo_rst),
		.zero     (zero),
		.freq     (freq),
		.wave     (wave),
		.tick     (tick),
		.wave_sel (wave_sel),
		.cnt_lim  (cnt_lim),
		.sq_flip  (sq_flip),
		.sq_high  (sq_high)
	);

	lfo_am_gen lfo_am_gen_inst (
		.clk      (clk),
		.rst      (rst),
		.lfo_rst  (lfo_rst),
		.tick     (tick),
		.wave_sel (wave_sel),
		.cnt_lim  (cnt_lim),
		.sq_flip  (sq_flip),
		.sq_high  (sq_high),
		.amd      (amd),
		.noise_am (noise_am),
		.am       (am)
	);

	lfo_pm_gen lfo_pm_gen_inst (
		.clk      (clk),
		.rst      (rst),
		.lfo_rst  (lfo_rst),
		.tick     (tick),
		.wave_sel (wave_sel),
		.cnt_lim  (cnt_lim),
		.sq_flip  (sq_flip),
		.sq_high  (sq_high),
		.pmd      (pmd),
		.noise_pm (noise_pm),
		.pm_u     (pm_u)
	);

	lfo_noise lfo_noise_inst (
		.clk      (clk),
		.rst      (rst),
		.tick     (tick),
		.noise_am (noise_am),
		.noise_pm (noise_pm)
	);

endmodule

`default_nettype wire

/* src/lfo_noise.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lfo_consts.svh"

module lfo_noise (
	input  wire                  clk,
	input  wire                  rst,
	input  wire                  tick,
	output logic [`LFO_AM_W-1:0] noise_am,
	output logic [`LFO_PM_W-1:0] noise_pm
);

	localparam int LFSR_W = 17;
	localparam int NUM    = `LFO_AM_W + `LFO_PM_W;

	logic [NUM-1:0] noise_bits;

	// One independent generator per output bit.
	for (genvar i = 0; i < NUM; i++) begin : g_lfsr
		// Top nibble is never zero, so no seed locks up.
		localparam logic [LFSR_W-1:0] SEED = {4'(i + 1), 13'(i * i * 97 + 11)};

		logic [LFSR_W-1:0] lfsr;

		always_ff @(posedge clk) begin
			if (rst) begin
				lfsr <= SEED;
			end else if (tick) begin
				// Taps 17 and 14, maximal length.
				lfsr <= {lfsr[LFSR_W-2:0], lfsr[LFSR_W-1] ^ lfsr[LFSR_W-4]};
			end
		end

		assign noise_bits[i] = lfsr[LFSR_W-1];
	end

	assign noise_am = noise_bits[`LFO_AM_W-1:0];
	assign noise_pm = noise_bits[NUM-1:`LFO_AM_W]; // Top bit is the pitch sign.

endmodule

`default_nettype wire

/* src/lfo_pm_gen.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lfo_consts.svh"

module lfo_pm_gen (
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       lfo_rst,
	input  wire                       tick,
	input  wire lfo_pkg::lfo_wave_e   wave_sel,
	input  wire  [`LFO_LIM_W-1:0]     cnt_lim,
	input  wire                       sq_flip,
	input  wire                       sq_high,
	input  wire  [`LFO_PM_W-2:0]      pmd,
	input  wire  [`LFO_PM_W-1:0]      noise_pm,
	output logic [`LFO_PM_W-1:0]      pm_u
);
	import lfo_pkg::*;

	localparam int ACC_W = `LFO_PM_W + 2;

	logic signed [`LFO_PM_W-1:0] pm;
	logic signed [`LFO_PM_W-1:0] pmd_pos;
	logic signed [`LFO_PM_W-1:0] pmd_neg;
	logic signed [ACC_W-1:0]     acc;
	logic signed [ACC_W-1:0]     acc_add;
	logic signed [ACC_W-1:0]     acc_step;
	logic                        step;
	ramp_dir_e                   dir;
	logic [`LFO_PM_W-1:0]        noise_val;

	assign pmd_pos = $signed({1'b0, pmd});
	assign pmd_neg = -pmd_pos;

	// A pitch step costs one limit since its range is twice as wide as am.
	assign acc_add  = acc + $signed(ACC_W'(pmd));
	assign acc_step = acc_add - $signed(ACC_W'(cnt_lim));
	assign step     = acc > 0;

	// Sign-extend the noise above the leading one of pmd.
	always_comb begin
		logic seen;
		seen = 1'b0;
		noise_val[`LFO_PM_W-1] = noise_pm[`LFO_PM_W-1];
		for (int i = `LFO_PM_W - 2; i >= 0; i--) begin
			seen         = seen | pmd[i];
			noise_val[i] = seen ? noise_pm[i] : noise_pm[`LFO_PM_W-1];
		end
		if (pmd == '0) begin
			noise_val = '0; // Zero depth gives no pitch noise.
		end
	end

	always_ff @(posedge clk) begin
		if (rst || lfo_rst) begin
			pm  <= '0;
			acc <= '0;
			dir <= RAMP_UP;
		end else if (tick) begin
			case (wave_sel)
				WAVE_SAW: begin
					if (step) begin
						if (pm == pmd_pos) begin
							pm  <= pmd_neg; // Jump to the negative bound.
							acc <= '0;
						end else begin
							pm  <= pm + 1'b1;
							acc <= acc_step;
						end
					end else begin
						acc <= acc_add;
					end
				end
				WAVE_TRI: begin
					if (step) begin
						if (dir == RAMP_UP && pm == pmd_pos) begin
							dir <= RAMP_DOWN;
							acc <= '0;
						end else if (dir == RAMP_DOWN && pm == pmd_neg) begin
							dir <= RAMP_UP;
							acc <= '0;
						end else begin
							pm  <= (dir == RAMP_UP) ? pm + 1'b1 : pm - 1'b1;
							acc <= acc_step;
						end
					end else begin
						acc <= acc_add;
					end
				end
				WAVE_SQUARE: begin
					if (sq_flip) begin
						pm <= sq_high ? pmd_pos : pmd_neg;
					end
				end
				default: pm <= noise_val;
			endcase
		end
	end

	// Sign over magnitude with the low bits of negative values inverted.
	assign pm_u = {pm[`LFO_PM_W-1],
		pm[`LFO_PM_W-1] ? ~pm[`LFO_PM_W-2:0] : pm[`LFO_PM_W-2:0]};

endmodule

`default_nettype wire

/* src/lfo_am_gen.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lfo_consts.svh"

module lfo_am_gen (
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       lfo_rst,
	input  wire                       tick,
	input  wire lfo_pkg::lfo_wave_e   wave_sel,
	input  wire  [`LFO_LIM_W-1:0]     cnt_lim,
	input  wire                       sq_flip,
	input  wire                       sq_high,
	input  wire  [`LFO_AM_W-1:0]      amd,
	input  wire  [`LFO_AM_W-1:0]      noise_am,
	output logic [`LFO_AM_W-1:0]      am
);
	import lfo_pkg::*;

	localparam int ACC_W = `LFO_AM_W + 4;

	logic signed [ACC_W-1:0] acc;
	logic signed [ACC_W-1:0] acc_add;
	logic signed [ACC_W-1:0] acc_step;
	logic                    step;
	ramp_dir_e               dir;
	logic [`LFO_AM_W-1:0]    noise_mask;

	// Bresenham error term, depth in and twice the limit out per step.
	assign acc_add  = acc + $signed(ACC_W'(amd));
	assign acc_step = acc_add - $signed(ACC_W'({cnt_lim, 1'b0}));
	assign step     = acc > 0;

	// Keep only the noise bits up to the leading one of amd.
	always_comb begin
		logic seen;
		seen = 1'b0;
		for (int i = `LFO_AM_W - 1; i >= 0; i--) begin
			seen          = seen | amd[i];
			noise_mask[i] = seen;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || lfo_rst) begin
			am  <= '0;
			acc <= '0;
			dir <= RAMP_UP;
		end else if (tick) begin
			case (wave_sel)
				WAVE_SAW: begin
					if (step) begin
						if (am == amd) begin
							am  <= '0; // Wrap to the bottom.
							acc <= '0;
						end else begin
							am  <= am + 1'b1;
							acc <= acc_step;
						end
					end else begin
						acc <= acc_add;
					end
				end
				WAVE_TRI: begin
					if (step) begin
						if (dir == RAMP_UP && am == amd) begin
							dir <= RAMP_DOWN;
							acc <= '0;
						end else if (dir == RAMP_DOWN && am == '0) begin
							dir <= RAMP_UP;
							acc <= '0;
						end else begin
							am  <= (dir == RAMP_UP) ? am + 1'b1 : am - 1'b1;
							acc <= acc_step;
						end
					end else begin
						acc <= acc_add;
					end
				end
				WAVE_SQUARE: begin
					if (sq_flip) begin
						am <= sq_high ? amd : '0;
					end
				end
				default: am <= noise_am & noise_mask;
			endcase
		end
	end

	// A ramp that starts inside the depth stays inside it.
	am_bound_chk: assert property (@(posedge clk) disable iff (rst)
		((wave_sel == WAVE_SAW || wave_sel == WAVE_TRI) && am <= amd)
		|=> am <= $past(amd));

endmodule

`default_nettype wire

/* src/lfo_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lfo_consts.svh"

module lfo_ctrl (
	input  wire                        clk,
	input  wire                        rst,
	input  wire                        lfo_rst,
	input  wire                        zero,
	input  wire  [7:0]                 freq,
	input  wire  [1:0]                 wave,
	output logic                       tick,
	output lfo_pkg::lfo_wave_e         wave_sel,
	output logic [`LFO_LIM_W-1:0]      cnt_lim,
	output logic                       sq_flip,
	output logic                       sq_high
);
	import lfo_pkg::*;

	logic [`LFO_BASE_W-1:0] base;
	logic [4:0]             freq_sel;
	logic [4:0]             tap_idx;
	logic                   sel_base;
	logic                   last_base;
	logic [`LFO_LIM_W-1:0]  sq_cnt;

	assign wave_sel = lfo_wave_e'(wave);

	// Free running sample counter that only a full reset restarts.
	always_ff @(posedge clk) begin
		if (rst) begin
			base <= '0;
		end else if (zero) begin
			base <= base + 1'b1;
		end
	end

	// Triangle runs one coarse step faster to keep the same period.
	always_comb begin
		freq_sel = {1'b0, freq[7:4]} + {4'd0, wave_sel == WAVE_TRI};
		tap_idx  = 5'(`LFO_BASE_OFS + 15) - {1'b0, freq_sel[3:0]};
		if (freq_sel[4]) begin
			sel_base = base[`LFO_BASE_OFS-1]; // Index 16 is the fastest rate.
		end else begin
			sel_base = base[tap_idx];
		end
	end

	// Any edge of the selected tap gives one tick a cycle later.
	always_ff @(posedge clk) begin
		if (rst) begin
			last_base <= 1'b0;
			tick      <= 1'b0;
		end else begin
			last_base <= sel_base;
			tick      <= sel_base != last_base;
		end
	end

	// Fine rate limit for the ramps and the square counter.
	always_comb begin
		case (freq[3:0])
			4'h0: cnt_lim = 8'd128;
			4'h1: cnt_lim = 8'd120;
			4'h2: cnt_lim = 8'd114;
			4'h3: cnt_lim = 8'd108;
			4'h4: cnt_lim = 8'd102;
			4'h5: cnt_lim = 8'd98;
			4'h6: cnt_lim = 8'd93;
			4'h7: cnt_lim = 8'd89;
			4'h8: cnt_lim = 8'd85;
			4'h9: cnt_lim = 8'd82;
			4'ha: cnt_lim = 8'd79;
			4'hb: cnt_lim = 8'd76;
			4'hc: cnt_lim = 8'd73;
			4'hd: cnt_lim = 8'd70;
			4'he: cnt_lim = 8'd68;
			default: cnt_lim = 8'd66;
		endcase
	end

	assign sq_flip = tick && wave_sel == WAVE_SQUARE && sq_cnt == cnt_lim;

	// Square half period counter.
	always_ff @(posedge clk) begin
		if (rst || lfo_rst) begin
			sq_cnt  <= '0;
			sq_high <= 1'b0;
		end else if (sq_flip) begin
			sq_cnt  <= '0;
			sq_high <= ~sq_high; // Level for the next flip.
		end else if (tick && wave_sel == WAVE_SQUARE) begin
			sq_cnt <= sq_cnt + 1'b1;
		end
	end

	// The half period counter flips at the limit and never runs past it.
	sq_cnt_chk: assert property (@(posedge clk) disable iff (rst || lfo_rst)
		(wave_sel == WAVE_SQUARE && sq_cnt <= cnt_lim)
		|=> (sq_cnt <= cnt_lim || cnt_lim != $past(cnt_lim)));

endmodule

`default_nettype wire

/* src/lfo_pkg.sv */
`default_nettype none

package lfo_pkg;

	// Waveform select, encoded as in the wave register field.
	typedef enum logic [1:0] {
		WAVE_SAW    = 2'd0, // Rising ramp with wrap.
		WAVE_SQUARE = 2'd1, // Two levels that toggle every cnt_lim plus one ticks.
		WAVE_TRI    = 2'd2, // Up and down ramp on a one step faster tap.
		WAVE_NOISE  = 2'd3  // Sampled LFSR bits.
	} lfo_wave_e;

	// Triangle ramp direction.
	typedef enum logic {
		RAMP_UP   = 1'b0,
		RAMP_DOWN = 1'b1
	} ramp_dir_e;

endpackage

`default_nettype wire

/* src/lfo_consts.svh */
`ifndef LFO_CONSTS_SVH
`define LFO_CONSTS_SVH

// Amplitude word and amplitude depth.
`define LFO_AM_W 7

// Internal signed pitch value and pm_u, sign bit included.
`define LFO_PM_W 8

// Fastest coarse rate taps the base counter at this bit minus one.
`define LFO_BASE_OFS 3

// Base counter width, covers all sixteen slower taps.
`define LFO_BASE_W 19

// Fine-rate limit word from the freq[3:0] table.
`define LFO_LIM_W 8

`endif
